//--- hdl/execPkg.sv
`default_nettype none

package execPkg;

  // Data and address width, fixed by RV32I
  localparam int XLEN = 32;

  // Execute-stage operations
  typedef enum logic [4:0] {
    addOp,
    subOp,
    sllOp,
    sltOp,
    sltuOp,
    xorOp,
    srlOp,
    sraOp,
    orOp,
    andOp,
    // Upper immediates and jumps
    luiOp,
    auipcOp,
    jalOp,
    jalrOp,
    // Conditional branches
    beqOp,
    bneOp,
    bltOp,
    bgeOp,
    bltuOp,
    bgeuOp,
    // Loads
    lbOp,
    lhOp,
    lwOp,
    lbuOp,
    lhuOp,
    // Stores
    sbOp,
    shOp,
    swOp
  } AluOp;

  // Source of a register operand
  typedef enum logic [1:0] {
    bypassNone = 2'd0,
    bypassExec = 2'd1,
    bypassMem  = 2'd2
  } BypassSel;

  // Access size of a load or store
  typedef enum logic [1:0] {
    memByte = 2'd0,
    memHalf = 2'd1,
    memWord = 2'd2
  } MemWidth;

endpackage

`default_nettype wire

//--- hdl/operandSelect.sv
`timescale 1ns/1ps
`default_nettype none

module operandSelect (
  input  logic [execPkg::XLEN-1:0] rs1Data,
  input  logic [execPkg::XLEN-1:0] rs2Data,
  input  logic [execPkg::XLEN-1:0] exFwdData,
  input  logic [execPkg::XLEN-1:0] memFwdData,
  input  logic [execPkg::XLEN-1:0] pc,
  input  logic [execPkg::XLEN-1:0] imm,
  input  execPkg::BypassSel        op1Bypass,
  input  execPkg::BypassSel        op2Bypass,
  input  execPkg::AluOp            aluOp,
  output logic [execPkg::XLEN-1:0] rs1Val,
  output logic [execPkg::XLEN-1:0] rs2Val,
  output logic [execPkg::XLEN-1:0] aluA,
  output logic [execPkg::XLEN-1:0] aluB,
  output logic [execPkg::XLEN-1:0] tgtBase,
  output logic [execPkg::XLEN-1:0] tgtOffset
);
  import execPkg::*;

  function automatic logic [XLEN-1:0] pickOperand(
    input BypassSel        sel,
    input logic [XLEN-1:0] regVal,
    input logic [XLEN-1:0] exVal,
    input logic [XLEN-1:0] memVal
  );
    case (sel)
      bypassExec: pickOperand = exVal;
      bypassMem:  pickOperand = memVal;
      default:    pickOperand = regVal;
    endcase
  endfunction

  assign rs1Val = pickOperand(op1Bypass, rs1Data, exFwdData, memFwdData);
  assign rs2Val = pickOperand(op2Bypass, rs2Data, exFwdData, memFwdData);

  always_comb begin
    case (aluOp)
      addOp, subOp, sllOp, sltOp, sltuOp, xorOp, srlOp, sraOp, orOp, andOp,
      beqOp, bneOp, bltOp, bgeOp, bltuOp, bgeuOp: begin
        aluA = rs1Val;
        aluB = rs2Val;
      end
      // Link value pc + 4
      jalOp, jalrOp: begin
        aluA = pc;
        aluB = XLEN'(4);
      end
      auipcOp: begin
        aluA = pc;
        aluB = imm;
      end
      luiOp: begin
        aluA = '0;
        aluB = imm;
      end
      default: begin
        aluA = rs1Val;
        aluB = imm;
      end
    endcase
  end

  assign tgtBase   = (aluOp == jalrOp) ? rs1Val : pc;
  assign tgtOffset = imm;

  always_comb begin
    assert (op1Bypass inside {bypassNone, bypassExec, bypassMem} &&
            op2Bypass inside {bypassNone, bypassExec, bypassMem})
      else $error("operandSelect: unknown bypass select %0d/%0d", op1Bypass, op2Bypass);
  end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  execPkg::AluOp            aluOp,
  input  logic [execPkg::XLEN-1:0] aluA,
  input  logic [execPkg::XLEN-1:0] aluB,
  output logic [execPkg::XLEN-1:0] result,
  output logic                     isBranch,
  output logic                     taken,
  output logic                     isLoad,
  output logic                     isStore,
  output logic                     loadUnsigned,
  output execPkg::MemWidth         memWidth
);
  import execPkg::*;

  logic [4:0]      shamt;
  logic [XLEN-1:0] sum;
  logic            equal;
  logic            lessSigned;
  logic            lessUnsigned;

  assign shamt        = aluB[4:0];
  assign sum          = aluA + aluB;
  assign equal        = (aluA == aluB);
  assign lessSigned   = ($signed(aluA) < $signed(aluB));
  assign lessUnsigned = (aluA < aluB);

  always_comb begin
    case (aluOp)
      subOp:   result = aluA - aluB;
      sllOp:   result = aluA << shamt;
      sltOp:   result = XLEN'(lessSigned);
      sltuOp:  result = XLEN'(lessUnsigned);
      xorOp:   result = aluA ^ aluB;
      srlOp:   result = aluA >> shamt;
      sraOp:   result = $signed(aluA) >>> shamt;
      orOp:    result = aluA | aluB;
      andOp:   result = aluA & aluB;
      // add, lui, auipc, link value and memory address
      default: result = sum;
    endcase
  end

  // Branch condition
  always_comb begin
    isBranch = 1'b1;
    case (aluOp)
      beqOp:         taken = equal;
      bneOp:         taken = !equal;
      bltOp:         taken = lessSigned;
      bgeOp:         taken = !lessSigned;
      bltuOp:        taken = lessUnsigned;
      bgeuOp:        taken = !lessUnsigned;
      jalOp, jalrOp: taken = 1'b1;
      default: begin
        isBranch = 1'b0;
        taken    = 1'b0;
      end
    endcase
  end

  // Memory access decode
  always_comb begin
    isLoad       = 1'b0;
    isStore      = 1'b0;
    loadUnsigned = 1'b0;
    memWidth     = memWord;
    case (aluOp)
      lbOp, lbuOp: begin
        isLoad       = 1'b1;
        loadUnsigned = (aluOp == lbuOp);
        memWidth     = memByte;
      end
      lhOp, lhuOp: begin
        isLoad       = 1'b1;
        loadUnsigned = (aluOp == lhuOp);
        memWidth     = memHalf;
      end
      lwOp: begin
        isLoad = 1'b1;
      end
      sbOp: begin
        isStore  = 1'b1;
        memWidth = memByte;
      end
      shOp: begin
        isStore  = 1'b1;
        memWidth = memHalf;
      end
      swOp: begin
        isStore = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
  input  logic [execPkg::XLEN-1:0] pc,
  input  logic [execPkg::XLEN-1:0] tgtBase,
  input  logic [execPkg::XLEN-1:0] tgtOffset,
  input  logic [execPkg::XLEN-1:0] predNextPc,
  input  logic                     isBranch,
  input  logic                     taken,
  input  execPkg::AluOp            aluOp,
  output logic [execPkg::XLEN-1:0] nextPc,
  output logic                     mispredict
);
  import execPkg::*;

  logic [XLEN-1:0] targetSum;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] seqPc;

  assign targetSum = tgtBase + tgtOffset;
  assign seqPc     = pc + XLEN'(4);

  always_comb begin
    target = targetSum;
    // jalr target is always halfword aligned
    if (aluOp == jalrOp) begin
      target[0] = 1'b0;
    end
  end

  assign nextPc     = taken ? target : seqPc;
  assign mispredict = (nextPc != predNextPc);

  // Only control-transfer ops may redirect
  always_comb begin
    assert (!taken || isBranch)
      else $error("branchUnit: taken without isBranch, op %0d", aluOp);
  end

endmodule

`default_nettype wire

//--- hdl/exMemReg.sv
`timescale 1ns/1ps
`default_nettype none

module exMemReg (
  input  logic                     clk,
  input  logic                     arstN,
  input  logic                     flush,
  input  logic                     inValid,
  output logic                     inReady,
  input  logic [execPkg::XLEN-1:0] pc,
  input  logic [execPkg::XLEN-1:0] result,
  input  logic [execPkg::XLEN-1:0] storeData,
  input  execPkg::MemWidth         memWidth,
  input  logic                     isLoad,
  input  logic                     isStore,
  input  logic                     loadUnsigned,
  input  logic                     rdWrite,
  input  logic [4:0]               rd,
  input  logic                     isBranch,
  input  logic                     taken,
  input  logic [execPkg::XLEN-1:0] nextPc,
  input  logic                     mispredict,
  output logic                     outValid,
  input  logic                     outReady,
  output logic [execPkg::XLEN-1:0] outPc,
  output logic [execPkg::XLEN-1:0] outResult,
  output logic [execPkg::XLEN-1:0] outStoreData,
  output execPkg::MemWidth         outMemWidth,
  output logic                     outIsLoad,
  output logic                     outIsStore,
  output logic                     outLoadUnsigned,
  output logic                     outRdWrite,
  output logic [4:0]               outRd,
  output logic                     outIsBranch,
  output logic                     outTaken,
  output logic [execPkg::XLEN-1:0] outNextPc,
  output logic                     outMispredict
);

  logic load;

  // Space when empty or draining this cycle and not flushing
  assign inReady = !flush && (!outValid || outReady);
  assign load    = inValid && inReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid      <= 1'b0;
      outIsLoad     <= 1'b0;
      outIsStore    <= 1'b0;
      outRdWrite    <= 1'b0;
      outIsBranch   <= 1'b0;
      outTaken      <= 1'b0;
      outMispredict <= 1'b0;
    end else if (flush) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
      if (inValid) begin
        outIsLoad     <= isLoad;
        outIsStore    <= isStore;
        outRdWrite    <= rdWrite;
        outIsBranch   <= isBranch;
        outTaken      <= taken;
        outMispredict <= mispredict;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (load) begin
      outPc           <= pc;
      outResult       <= result;
      outStoreData    <= storeData;
      outMemWidth     <= memWidth;
      outLoadUnsigned <= loadUnsigned;
      outRd           <= rd;
      outNextPc       <= nextPc;
    end
  end

  property holdWhileStalled;
    @(posedge clk) disable iff (!arstN)
      outValid && !outReady && !flush |=> outValid && $stable(outPc) &&
        $stable(outResult) && $stable(outStoreData) && $stable(outMemWidth) &&
        $stable(outIsLoad) && $stable(outIsStore) && $stable(outLoadUnsigned) &&
        $stable(outRdWrite) && $stable(outRd) && $stable(outIsBranch) &&
        $stable(outTaken) && $stable(outNextPc) && $stable(outMispredict);
  endproperty

  assert property (holdWhileStalled)
    else $error("exMemReg: output changed under back-pressure");

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic                     clk,
  input  logic                     arstN,
  input  logic                     flush,
  input  logic                     inValid,
  output logic                     inReady,
  input  logic [execPkg::XLEN-1:0] inPc,
  input  logic [execPkg::XLEN-1:0] inRs1Data,
  input  logic [execPkg::XLEN-1:0] inRs2Data,
  input  logic [execPkg::XLEN-1:0] inImm,
  input  execPkg::AluOp            inAluOp,
  input  execPkg::BypassSel        inOp1Bypass,
  input  execPkg::BypassSel        inOp2Bypass,
  input  logic [execPkg::XLEN-1:0] inPredNextPc,
  input  logic [4:0]               inRd,
  input  logic                     inRdWrite,
  input  logic [execPkg::XLEN-1:0] exFwdData,
  input  logic [execPkg::XLEN-1:0] memFwdData,
  output logic                     outValid,
  input  logic                     outReady,
  output logic [execPkg::XLEN-1:0] outPc,
  output logic [execPkg::XLEN-1:0] outResult,
  output logic [execPkg::XLEN-1:0] outStoreData,
  output execPkg::MemWidth         outMemWidth,
  output logic                     outIsLoad,
  output logic                     outIsStore,
  output logic                     outLoadUnsigned,
  output logic                     outRdWrite,
  output logic [4:0]               outRd,
  output logic                     outIsBranch,
  output logic                     outTaken,
  output logic [execPkg::XLEN-1:0] outNextPc,
  output logic                     outMispredict
);
  import execPkg::*;

  logic [XLEN-1:0] rs1Val;
  logic [XLEN-1:0] rs2Val;
  logic [XLEN-1:0] aluA;
  logic [XLEN-1:0] aluB;
  logic [XLEN-1:0] tgtBase;
  logic [XLEN-1:0] tgtOffset;
  logic [XLEN-1:0] result;
  logic [XLEN-1:0] nextPc;
  logic            isBranch;
  logic            taken;
  logic            isLoad;
  logic            isStore;
  logic            loadUnsigned;
  logic            mispredict;
  MemWidth         memWidth;

  operandSelect uOperandSelect (
    .rs1Data(inRs1Data), .rs2Data(inRs2Data),
    .exFwdData(exFwdData), .memFwdData(memFwdData),
    .pc(inPc), .imm(inImm),
    .op1Bypass(inOp1Bypass), .op2Bypass(inOp2Bypass), .aluOp(inAluOp),
    .rs1Val(rs1Val), .rs2Val(rs2Val), .aluA(aluA), .aluB(aluB),
    .tgtBase(tgtBase), .tgtOffset(tgtOffset)
  );

  alu uAlu (
    .aluOp(inAluOp), .aluA(aluA), .aluB(aluB), .result(result),
    .isBranch(isBranch), .taken(taken), .isLoad(isLoad), .isStore(isStore),
    .loadUnsigned(loadUnsigned), .memWidth(memWidth)
  );

  branchUnit uBranchUnit (
    .pc(inPc), .tgtBase(tgtBase), .tgtOffset(tgtOffset), .predNextPc(inPredNextPc),
    .isBranch(isBranch), .taken(taken), .aluOp(inAluOp),
    .nextPc(nextPc), .mispredict(mispredict)
  );

  // rd travels untouched alongside the operation
  exMemReg uExMemReg (
    .clk(clk), .arstN(arstN), .flush(flush),
    .inValid(inValid), .inReady(inReady),
    .pc(inPc), .result(result), .storeData(rs2Val), .memWidth(memWidth),
    .isLoad(isLoad), .isStore(isStore), .loadUnsigned(loadUnsigned),
    .rdWrite(inRdWrite), .rd(inRd), .isBranch(isBranch), .taken(taken),
    .nextPc(nextPc), .mispredict(mispredict),
    .outValid(outValid), .outReady(outReady),
    .outPc(outPc), .outResult(outResult), .outStoreData(outStoreData),
    .outMemWidth(outMemWidth), .outIsLoad(outIsLoad), .outIsStore(outIsStore),
    .outLoadUnsigned(outLoadUnsigned), .outRdWrite(outRdWrite), .outRd(outRd),
    .outIsBranch(outIsBranch), .outTaken(outTaken), .outNextPc(outNextPc),
    .outMispredict(outMispredict)
  );

endmodule

`default_nettype wire

//--- dv/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic arstN
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/executeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module executeStageTb;
  import execPkg::*;

  localparam int arithOps   = 60;
  localparam int fwdOps     = 40;
  localparam int branchOps  = 60;
  localparam int memOps     = 40;
  localparam int flowOps    = 60;
  localparam int totalOps   = arithOps + fwdOps + branchOps + memOps + flowOps;
  localparam int cycleLimit = 2 * totalOps + 200;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] result;
    logic        resultCare;
    logic [31:0] storeData;
    MemWidth     memWidth;
    logic        isLoad;
    logic        isStore;
    logic        loadUnsigned;
    logic        rdWrite;
    logic [4:0]  rd;
    logic        isBranch;
    logic        taken;
    logic [31:0] nextPc;
    logic        mispredict;
  } Expect;

  logic            clk;
  logic            arstN;
  logic            flush = 1'b0;
  logic            inValid = 1'b0;
  logic            inReady;
  logic [XLEN-1:0] inPc = '0;
  logic [XLEN-1:0] inRs1Data = '0;
  logic [XLEN-1:0] inRs2Data = '0;
  logic [XLEN-1:0] inImm = '0;
  AluOp            inAluOp = addOp;
  BypassSel        inOp1Bypass = bypassNone;
  BypassSel        inOp2Bypass = bypassNone;
  logic [XLEN-1:0] inPredNextPc = '0;
  logic [4:0]      inRd = '0;
  logic            inRdWrite = 1'b0;
  logic [XLEN-1:0] exFwdData = '0;
  logic [XLEN-1:0] memFwdData = '0;
  logic            outValid;
  logic            outReady = 1'b1;
  logic [XLEN-1:0] outPc;
  logic [XLEN-1:0] outResult;
  logic [XLEN-1:0] outStoreData;
  MemWidth         outMemWidth;
  logic            outIsLoad;
  logic            outIsStore;
  logic            outLoadUnsigned;
  logic            outRdWrite;
  logic [4:0]      outRd;
  logic            outIsBranch;
  logic            outTaken;
  logic [XLEN-1:0] outNextPc;
  logic            outMispredict;

  Expect       expected[$];
  logic [31:0] lfsrState = 32'h58d3_6fda;
  logic [31:0] stallLfsr = 32'h58d3_6fda;
  logic        stallMode = 1'b0;
  int          cycles = 0;
  int          flushCycle = -1;
  int          checks = 0;
  int          errors = 0;
  int          kills = 0;

  clockGen uClockGen (.clk(clk), .arstN(arstN));

  executeStage DUT (.*);

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  // Opcode pools in enum order
  // 0-11 ALU, 12-13 jumps, 14-19 branches, 20-27 memory
  function automatic AluOp pickOp(input int kind);
    logic [4:0] code;
    case (kind)
      1: code = 5'(randBits(4) % 12);
      2: begin
        code = 5'(randBits(4) % 13);
        if (code >= 5'd10) code = code + 5'd15;
      end
      3:       code = 5'(randBits(3) + 12);
      4:       code = 5'(randBits(3) + 20);
      default: code = 5'(randBits(5) % 28);
    endcase
    return AluOp'(code);
  endfunction

  function automatic Expect refModel(
    input logic [31:0] pc, rs1, rs2, imm, exF, memF, pred,
    input AluOp op,
    input BypassSel b1, b2,
    input logic [4:0] rd,
    input logic rdWrite
  );
    Expect       e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] tgt;
    a = (b1 == bypassExec) ? exF : (b1 == bypassMem) ? memF : rs1;
    b = (b2 == bypassExec) ? exF : (b2 == bypassMem) ? memF : rs2;
    e = '0;
    e.pc         = pc;
    e.storeData  = b;
    e.rd         = rd;
    e.rdWrite    = rdWrite;
    e.resultCare = 1'b1;
    case (op)
      addOp:   e.result = a + b;
      subOp:   e.result = a - b;
      sllOp:   e.result = a << b[4:0];
      sltOp:   e.result = {31'b0, $signed(a) < $signed(b)};
      sltuOp:  e.result = {31'b0, a < b};
      xorOp:   e.result = a ^ b;
      srlOp:   e.result = a >> b[4:0];
      sraOp:   e.result = $signed(a) >>> b[4:0];
      orOp:    e.result = a | b;
      andOp:   e.result = a & b;
      luiOp:   e.result = imm;
      auipcOp: e.result = pc + imm;
      jalOp, jalrOp: begin
        e.result   = pc + 32'd4;
        e.isBranch = 1'b1;
        e.taken    = 1'b1;
      end
      beqOp, bneOp, bltOp, bgeOp, bltuOp, bgeuOp: begin
        // Branch result is not architectural
        e.resultCare = 1'b0;
        e.isBranch   = 1'b1;
        case (op)
          beqOp:   e.taken = (a == b);
          bneOp:   e.taken = (a != b);
          bltOp:   e.taken = ($signed(a) < $signed(b));
          bgeOp:   e.taken = ($signed(a) >= $signed(b));
          bltuOp:  e.taken = (a < b);
          default: e.taken = (a >= b);
        endcase
      end
      default: begin
        e.result       = a + imm;
        e.isLoad       = op inside {lbOp, lhOp, lwOp, lbuOp, lhuOp};
        e.isStore      = !e.isLoad;
        e.loadUnsigned = op inside {lbuOp, lhuOp};
        e.memWidth     = (op inside {lbOp, lbuOp, sbOp}) ? memByte :
                         (op inside {lhOp, lhuOp, shOp}) ? memHalf : memWord;
      end
    endcase
    tgt = (op == jalrOp) ? ((a + imm) & ~32'h1) : (pc + imm);
    e.nextPc     = e.taken ? tgt : pc + 32'd4;
    e.mispredict = (e.nextPc != pred);
    return e;
  endfunction

  task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compareOutput(input Expect e);
    checkField("outPc", outPc, e.pc);
    if (e.resultCare) checkField("outResult", outResult, e.result);
    checkField("outStoreData", outStoreData, e.storeData);
    if (e.isLoad || e.isStore) checkField("outMemWidth", 32'(outMemWidth), 32'(e.memWidth));
    checkField("outIsLoad", 32'(outIsLoad), 32'(e.isLoad));
    checkField("outIsStore", 32'(outIsStore), 32'(e.isStore));
    checkField("outLoadUnsigned", 32'(outLoadUnsigned), 32'(e.loadUnsigned));
    checkField("outRdWrite", 32'(outRdWrite), 32'(e.rdWrite));
    checkField("outRd", 32'(outRd), 32'(e.rd));
    checkField("outIsBranch", 32'(outIsBranch), 32'(e.isBranch));
    checkField("outTaken", 32'(outTaken), 32'(e.taken));
    checkField("outNextPc", outNextPc, e.nextPc);
    checkField("outMispredict", 32'(outMispredict), 32'(e.mispredict));
  endtask

  // Scoreboard sampled before the edge updates the register
  always @(posedge clk) begin
    if (arstN) begin
      if (flush && outValid) begin
        void'(expected.pop_front());
        kills++;
      end else if (outValid && outReady) begin
        checks++;
        assert (expected.size() != 0) else begin
          $display("output transfer with no operation outstanding");
          errors++;
        end
        if (expected.size() != 0) compareOutput(expected.pop_front());
      end
      if (inValid && inReady) begin
        expected.push_back(refModel(inPc, inRs1Data, inRs2Data, inImm, exFwdData,
          memFwdData, inPredNextPc, inAluOp, inOp1Bypass, inOp2Bypass, inRd, inRdWrite));
      end
    end
  end

  // Back-pressure and flush pulse
  always @(negedge clk) begin
    if (cycles == flushCycle) begin
      flush    = 1'b1;
      outReady = 1'b0;
    end else begin
      flush = 1'b0;
      if (stallMode) begin
        stallLfsr = lfsrNext(stallLfsr);
        outReady  = stallLfsr[0];
      end else begin
        outReady = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout: run exceeded %0d cycles", cycleLimit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic sendOp(input int kind);
    logic [31:0] pcVal;
    @(negedge clk);
    pcVal        = randBits(32) & ~32'h3;
    inAluOp      = pickOp(kind);
    inPc         = pcVal;
    inRs1Data    = randBits(32);
    inRs2Data    = (kind == 3 && randBits(2) == 0) ? inRs1Data : randBits(32);
    inImm        = randBits(32);
    inPredNextPc = randBits(1) ? pcVal + 32'd4 : pcVal + inImm;
    inOp1Bypass  = (kind == 2 || kind == 5) ? BypassSel'(2'(randBits(2) % 3)) : bypassNone;
    inOp2Bypass  = (kind == 2 || kind == 5) ? BypassSel'(2'(randBits(2) % 3)) : bypassNone;
    inRd         = 5'(randBits(5));
    inRdWrite    = 1'(randBits(1));
    exFwdData    = randBits(32);
    memFwdData   = randBits(32);
    inValid      = 1'b1;
    do @(posedge clk); while (!inReady);
  endtask

  task automatic runTest(input string name, input int kind, input int count);
    int errorsBefore;
    errorsBefore = errors;
    for (int i = 0; i < count; i++) sendOp(kind);
    @(negedge clk);
    inValid = 1'b0;
    while (expected.size() != 0) @(negedge clk);
    $display("%s: %0d ops, %0d errors", name, count, errors - errorsBefore);
  endtask

  initial begin
    @(posedge arstN);
    @(posedge clk);
    checkField("inReady", 32'(inReady), 32'd1);
    checkField("outValid", 32'(outValid), 32'd0);
    checkField("outMispredict", 32'(outMispredict), 32'd0);
    checkField("outIsLoad", 32'(outIsLoad), 32'd0);
    checkField("outIsStore", 32'(outIsStore), 32'd0);
    checkField("outRdWrite", 32'(outRdWrite), 32'd0);
    checkField("outIsBranch", 32'(outIsBranch), 32'd0);
    $display("reset: %0d errors", errors);
    runTest("arithmetic", 1, arithOps);
    runTest("forwarding", 2, fwdOps);
    runTest("branches", 3, branchOps);
    runTest("loads and stores", 4, memOps);
    @(posedge clk);
    stallMode = 1'b1;
    @(negedge clk);
    flushCycle = cycles + 20;
    runTest("flow control", 5, flowOps);
    checks++;
    assert (kills > 0) else begin
      $display("flush pulse did not kill a valid operation");
      errors++;
    end
    $display("checks passed: %0d, errors: %0d", checks - errors, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- executeStage.f
hdl/execPkg.sv
hdl/operandSelect.sv
hdl/alu.sv
hdl/branchUnit.sv
hdl/exMemReg.sv
hdl/executeStage.sv
dv/clockGen.sv
dv/executeStageTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= executeStageTb
FILELIST  ?= executeStage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
